// ==== hw/chan_pkg.sv ====
// Shared sample, mask-write and output word types plus size limits; imported by the channelizer RTL
`default_nettype none

package chan_pkg;

    // wide enough for a 2048 bin transform
    localparam int BIN_IDX_W = 11;

    // smallest FFT size the decode accepts
    localparam int FFT_SIZE_MIN = 8;

    // cycles of internal reset after a configuration change
    localparam int RESET_STRETCH_CYCLES = 8;

    // one bin sample, I in data[31:16], Q in data[15:0]
    typedef struct packed {
        logic                 valid;
        logic [31:0]          data;
        logic [BIN_IDX_W-1:0] bin;
    } chan_sample_t;

    // one write into the bin enable mask
    typedef struct packed {
        logic                 valid;
        logic [BIN_IDX_W-1:0] bin;
        logic                 keep;
    } chan_select_t;

    // output word, last marks the end of a payload
    typedef struct packed {
        logic                 valid;
        logic [31:0]          data;
        logic [BIN_IDX_W-1:0] bin;
        logic                 last;
    } chan_out_t;

endpackage

`default_nettype wire

// ==== hw/chan_ctrl.sv ====
// Registers FFT size and payload length, decodes log2 size and stretches the datapath reset
`timescale 1ns/100ps
`default_nettype none

module chan_ctrl #(
    parameter int MAX_BINS = 256
) (
    input  wire         clk,
    input  wire         sync_reset,
    input  wire  [11:0] fft_size_i,
    input  wire  [15:0] payload_len_i,
    output logic [11:0] fft_size_o,
    output logic [4:0]  fft_log2_o,
    output logic [15:0] payload_len_o,
    output logic        run_reset_o
);
    import chan_pkg::*;

    localparam int CNT_W = $clog2(RESET_STRETCH_CYCLES + 1);
    localparam logic [11:0] DEF_SIZE = 12'd128;
    localparam logic [4:0]  DEF_LOG2 = 5'd7;

    // raw copies of the requests, used only for change detection
    logic [11:0]      fft_req_q;
    logic [15:0]      len_req_q;
    logic [CNT_W-1:0] stretch_cnt;
    logic [11:0]      size_dec;
    logic [4:0]       log2_dec;
    logic [15:0]      len_dec;
    logic             cfg_change;

    // accept powers of two in range, otherwise fall back to the largest size
    always_comb begin
        size_dec = 12'(MAX_BINS);
        log2_dec = 5'($clog2(MAX_BINS));
        for (int k = $clog2(FFT_SIZE_MIN); k <= 11; k++) begin
            if (((1 << k) <= MAX_BINS) && (fft_size_i == 12'(1 << k))) begin
                size_dec = 12'(1 << k);
                log2_dec = 5'(k);
            end
        end
    end

    // zero length payloads are treated as single words
    assign len_dec = (payload_len_i == 16'd0) ? 16'd1 : payload_len_i;

    assign cfg_change = (fft_size_i != fft_req_q) || (payload_len_i != len_req_q);

    always_ff @(posedge clk, posedge sync_reset) begin
        if (sync_reset) begin
            fft_req_q     <= DEF_SIZE;
            len_req_q     <= 16'd1;
            fft_size_o    <= DEF_SIZE;
            fft_log2_o    <= DEF_LOG2;
            payload_len_o <= 16'd1;
            stretch_cnt   <= CNT_W'(RESET_STRETCH_CYCLES);
        end else begin
            if (cfg_change) begin
                fft_req_q     <= fft_size_i;
                len_req_q     <= payload_len_i;
                fft_size_o    <= size_dec;
                fft_log2_o    <= log2_dec;
                payload_len_o <= len_dec;
                stretch_cnt   <= CNT_W'(RESET_STRETCH_CYCLES);
            end else if (stretch_cnt != '0) begin
                stretch_cnt <= stretch_cnt - 1'b1;
            end
        end
    end

    // high from the reload edge until the count runs out
    assign run_reset_o = (stretch_cnt != '0);

endmodule

`default_nettype wire

// ==== hw/bin_framer.sv ====
// Tags each incoming sample with its bin index, wrapping at the configured FFT size
`timescale 1ns/100ps
`default_nettype none

module bin_framer (
    input  wire                    clk,
    input  wire                    sync_reset,
    input  wire                    run_reset_i,
    input  wire  [11:0]            fft_size_i,
    input  wire  chan_pkg::chan_sample_t sample_i,
    output chan_pkg::chan_sample_t sample_o
);
    import chan_pkg::*;

    logic [BIN_IDX_W-1:0] bin_cnt;
    logic [11:0]          wrap_at;
    logic                 valid_q;
    logic [31:0]          data_q;
    logic [BIN_IDX_W-1:0] bin_q;

    // never wrap below the smallest supported frame
    assign wrap_at = (fft_size_i < 12'(FFT_SIZE_MIN)) ? 12'(FFT_SIZE_MIN - 1) :
                     fft_size_i - 12'd1;

    always_ff @(posedge clk, posedge sync_reset) begin
        if (sync_reset) begin
            valid_q <= 1'b0;
            bin_cnt <= '0;
        end else if (run_reset_i) begin
            valid_q <= 1'b0;
            bin_cnt <= '0;
        end else begin
            valid_q <= sample_i.valid;
            if (sample_i.valid) begin
                bin_cnt <= (12'(bin_cnt) == wrap_at) ? '0 : bin_cnt + 1'b1;
            end
        end
    end

    // incoming bin field is discarded
    always_ff @(posedge clk) begin
        if (sample_i.valid) begin
            data_q <= sample_i.data;
            bin_q  <= bin_cnt;
        end
    end

    assign sample_o = '{valid: valid_q, data: data_q, bin: bin_q};

endmodule

`default_nettype wire

// ==== hw/bin_select.sv ====
// Drops samples whose bin is not enabled; the enable mask is written through select commands
`timescale 1ns/100ps
`default_nettype none

module bin_select #(
    parameter int  MAX_BINS  = 256,
    parameter type payload_t = chan_pkg::chan_sample_t
) (
    input  wire                    clk,
    input  wire                    sync_reset,
    input  wire                    run_reset_i,
    input  wire  chan_pkg::chan_select_t select_i,
    input  wire  payload_t         sample_i,
    output payload_t               sample_o
);

    localparam int IDX_W = (MAX_BINS > 1) ? $clog2(MAX_BINS) : 1;

    logic [MAX_BINS-1:0] bin_en;
    logic                sel_hit;
    logic                keep_hit;
    logic                valid_q;
    payload_t            data_q;

    // addresses past the mask depth are ignored
    assign sel_hit = select_i.valid && (select_i.bin < MAX_BINS);

    // reads the mask before this cycle's write lands
    assign keep_hit = sample_i.valid && (sample_i.bin < MAX_BINS) &&
                      bin_en[sample_i.bin[IDX_W-1:0]];

    always_ff @(posedge clk, posedge sync_reset) begin
        if (sync_reset) begin
            bin_en  <= '0;
            valid_q <= 1'b0;
        end else if (run_reset_i) begin
            // every bin disabled until selected again
            bin_en  <= '0;
            valid_q <= 1'b0;
        end else begin
            if (sel_hit) begin
                bin_en[select_i.bin[IDX_W-1:0]] <= select_i.keep;
            end
            valid_q <= keep_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (keep_hit) begin
            data_q <= sample_i;
        end
    end

    always_comb begin
        sample_o       = data_q;
        sample_o.valid = valid_q;
    end

endmodule

`default_nettype wire

// ==== hw/payload_packetizer.sv ====
// Counts forwarded words and flags the last word of each payload on the output bus
`timescale 1ns/100ps
`default_nettype none

module payload_packetizer #(
    parameter type payload_t = chan_pkg::chan_sample_t
) (
    input  wire                 clk,
    input  wire                 sync_reset,
    input  wire                 run_reset_i,
    input  wire  [15:0]         payload_len_i,
    input  wire  payload_t      sample_i,
    output chan_pkg::chan_out_t out_o
);

    logic [15:0] word_cnt;
    logic        at_last;
    logic        valid_q;
    logic        last_q;
    payload_t    data_q;

    assign at_last = (word_cnt == payload_len_i - 16'd1);

    always_ff @(posedge clk, posedge sync_reset) begin
        if (sync_reset) begin
            valid_q  <= 1'b0;
            word_cnt <= '0;
        end else if (run_reset_i) begin
            valid_q  <= 1'b0;
            word_cnt <= '0;
        end else begin
            valid_q <= sample_i.valid;
            if (sample_i.valid) begin
                // restart after the final word of a payload
                word_cnt <= at_last ? '0 : word_cnt + 16'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample_i.valid) begin
            data_q <= sample_i;
            last_q <= at_last;
        end
    end

    assign out_o = '{valid: valid_q, data: data_q.data, bin: data_q.bin, last: last_q};

endmodule

`default_nettype wire

// ==== hw/channelizer_top.sv ====
// Top level of the channelizer back end: control block feeding framer, bin select and packetizer
`timescale 1ns/100ps
`default_nettype none

module channelizer_top #(
    parameter int MAX_BINS = 256
) (
    input  wire                    clk,
    input  wire                    sync_reset,
    input  wire  chan_pkg::chan_sample_t sample_i,
    input  wire  chan_pkg::chan_select_t select_i,
    input  wire  [11:0]            fft_size_i,
    input  wire  [15:0]            payload_len_i,
    output wire  chan_pkg::chan_out_t    out_o,
    output wire  [4:0]             fft_log2_o
);
    import chan_pkg::*;

    logic         run_reset;
    logic [11:0]  fft_size_q;
    logic [15:0]  payload_len_q;
    chan_sample_t framed;
    chan_sample_t kept;

    chan_ctrl #(
        .MAX_BINS(MAX_BINS)
    ) u_ctrl (
        .clk(clk),
        .sync_reset(sync_reset),
        .fft_size_i(fft_size_i),
        .payload_len_i(payload_len_i),
        .fft_size_o(fft_size_q),
        .fft_log2_o(fft_log2_o),
        .payload_len_o(payload_len_q),
        .run_reset_o(run_reset)
    );

    bin_framer u_framer (
        .clk(clk),
        .sync_reset(sync_reset),
        .run_reset_i(run_reset),
        .fft_size_i(fft_size_q),
        .sample_i(sample_i),
        .sample_o(framed)
    );

    bin_select #(
        .MAX_BINS(MAX_BINS),
        .payload_t(chan_sample_t)
    ) u_select (
        .clk(clk),
        .sync_reset(sync_reset),
        .run_reset_i(run_reset),
        .select_i(select_i),
        .sample_i(framed),
        .sample_o(kept)
    );

    payload_packetizer #(
        .payload_t(chan_sample_t)
    ) u_packetizer (
        .clk(clk),
        .sync_reset(sync_reset),
        .run_reset_i(run_reset),
        .payload_len_i(payload_len_q),
        .sample_i(kept),
        .out_o(out_o)
    );

endmodule

`default_nettype wire

// ==== sim/tb_channelizer.sv ====
// Testbench for channelizer_top that replays the pattern file and checks out_o and fft_log2_o
`timescale 1ns/100ps
`default_nettype none

module tb_channelizer;
    import chan_pkg::*;

    logic         clk;
    logic         sync_reset;
    chan_sample_t sample_i;
    chan_select_t select_i;
    logic [11:0]  fft_size_i;
    logic [15:0]  payload_len_i;
    chan_out_t    out_o;
    logic [4:0]   fft_log2_o;

    // expected words and the cycle each one is due at the output
    chan_out_t    exp_q[$];
    int           due_q[$];
    string        lines[$];
    int           cycle_cnt = 0;
    int           cycle_limit = 1000;
    int           due_cyc;
    int           seed = 38695;
    int           out_errs = 0;
    int           log2_errs = 0;
    int           pattern_errs = 0;

    channelizer_top #(
        .MAX_BINS(256)
    ) i_dut (
        .clk(clk),
        .sync_reset(sync_reset),
        .sample_i(sample_i),
        .select_i(select_i),
        .fft_size_i(fft_size_i),
        .payload_len_i(payload_len_i),
        .out_o(out_o),
        .fft_log2_o(fft_log2_o)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    always @(posedge clk) begin
        if (cycle_cnt > cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycle_cnt);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check_out(input chan_out_t exp, input chan_out_t act);
        if (act !== exp) begin
            $display("MISMATCH at %0t: out_o expected {%h %0d %b}, got {%h %0d %b}",
                     $time, exp.data, exp.bin, exp.last, act.data, act.bin, act.last);
            out_errs++;
        end
    endtask

    task automatic check_log2(input logic [4:0] exp, input logic [4:0] act);
        if (act !== exp) begin
            $display("MISMATCH at %0t: fft_log2_o expected %0d, got %0d", $time, exp, act);
            log2_errs++;
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (out_o.valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("output word for bin %0d at %0t while none was expected",
                         out_o.bin, $time);
                out_errs++;
            end else begin
                check_out(exp_q.pop_front(), out_o);
                due_cyc = due_q.pop_front();
                if (due_cyc != cycle_cnt) begin
                    $display("output word for bin %0d arrived in cycle %0d, due in cycle %0d",
                             out_o.bin, cycle_cnt, due_cyc);
                    out_errs++;
                end
            end
        end
    end

    // advance one clock and drop the strobes again
    task automatic next_cycle();
        @(posedge clk);
        #1;
        sample_i.valid = 1'b0;
        select_i.valid = 1'b0;
    endtask

    // random incoming bin that the framer has to overwrite
    task automatic drive_sample(input logic [31:0] data);
        sample_i.valid = 1'b1;
        sample_i.data  = data;
        sample_i.bin   = BIN_IDX_W'($random(seed));
        next_cycle();
    endtask

    initial begin
        int          fd;
        int          steps;
        int          a;
        int          b;
        int          c;
        logic [31:0] d;
        logic [63:0] op;
        string       line;

        clk           = 1'b0;
        sync_reset    = 1'b1;
        sample_i      = '0;
        select_i      = '0;
        fft_size_i    = 12'd128;
        payload_len_i = 16'd1;
        steps         = 0;

        fd = $fopen("sim/channelizer_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open sim/channelizer_patterns.txt");
            pattern_errs++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) != 0 && line.len() > 1 && line[0] != "#") begin
                    lines.push_back(line);
                    a = 0;
                    b = 0;
                    void'($sscanf(line, "%s %d %d", op, a, b));
                    steps += 1;
                    if (op == 64'("burst") || op == 64'("idle")) begin
                        steps += a;
                    end
                    if (op == 64'("select")) begin
                        steps += b;
                    end
                end
            end
            $fclose(fd);
        end
        cycle_limit = 4 * steps + 100;

        repeat (3) @(posedge clk);
        #1;
        sync_reset = 1'b0;

        foreach (lines[i]) begin
            void'($sscanf(lines[i], "%s", op));
            if (op == 64'("config")) begin
                void'($sscanf(lines[i], "%s %d %d", op, a, b));
                fft_size_i    = a[11:0];
                payload_len_i = b[15:0];
                next_cycle();
            end else if (op == 64'("select")) begin
                void'($sscanf(lines[i], "%s %d %d %d", op, a, b, c));
                for (int k = 0; k < b; k++) begin
                    select_i.valid = 1'b1;
                    select_i.bin   = BIN_IDX_W'(a + k);
                    select_i.keep  = c[0];
                    next_cycle();
                end
            end else if (op == 64'("sample")) begin
                void'($sscanf(lines[i], "%s %h %d %d %d", op, d, c, a, b));
                if (c != 0) begin
                    exp_q.push_back(chan_out_t'{valid: 1'b1, data: d,
                                                bin: BIN_IDX_W'(a), last: b[0]});
                    due_q.push_back(cycle_cnt + 3);
                end
                drive_sample(d);
            end else if (op == 64'("burst")) begin
                void'($sscanf(lines[i], "%s %d %h", op, a, d));
                for (int k = 0; k < a; k++) begin
                    drive_sample(d + 32'(k));
                end
            end else if (op == 64'("log2")) begin
                void'($sscanf(lines[i], "%s %d", op, a));
                check_log2(a[4:0], fft_log2_o);
            end else if (op == 64'("idle")) begin
                void'($sscanf(lines[i], "%s %d", op, a));
                repeat (a) next_cycle();
            end else begin
                $display("unknown opcode in pattern line %0d: %s", i, lines[i]);
                pattern_errs++;
            end
        end

        // let the pipeline drain
        repeat (6) next_cycle();
        if (exp_q.size() != 0) begin
            $display("%0d expected output words never arrived", exp_q.size());
            pattern_errs += exp_q.size();
        end

        $display("errors: out_o %0d, fft_log2_o %0d, other %0d",
                 out_errs, log2_errs, pattern_errs);
        if (out_errs + log2_errs + pattern_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/channelizer_patterns.txt ====
# op and fields: data words in hex, all other fields decimal
# config size len | select bin count keep | sample data kept bin last | burst count data | log2 value | idle cycles
config 8 5
idle 9
log2 3
select 0 8 1
sample 00010001 1 0 0
sample 00020002 1 1 0
sample 00030003 1 2 0
sample 00040004 1 3 0
sample 00050005 1 4 1
sample 00060006 1 5 0
sample 00070007 1 6 0
sample 00080008 1 7 0
select 2 1 0
select 5 1 0
sample 00110011 1 0 0
sample 00120012 1 1 1
sample 00130013 0 0 0
sample 00140014 1 3 0
sample 00150015 1 4 0
sample 00160016 0 0 0
sample 00170017 1 6 0
sample 00180018 1 7 0
select 2 1 1
sample 00210021 1 0 1
sample 00220022 1 1 0
sample 00230023 1 2 0
idle 4
config 16 5
idle 9
log2 4
sample 00300030 0 0 0
select 0 1 1
burst 15 00300031
sample 00310031 1 0 0
idle 4
config 256 1
log2 8
config 100 1
log2 8
config 4096 1
idle 9
log2 8
select 0 1 1
sample 40000000 1 0 1
burst 255 40000001
sample 40000100 1 0 1

// ==== list.f ====
hw/chan_pkg.sv
hw/chan_ctrl.sv
hw/bin_framer.sv
hw/bin_select.sv
hw/payload_packetizer.sv
hw/channelizer_top.sv
sim/tb_channelizer.sv

// ==== run.sh ====
#!/bin/sh
# build and run the channelizer testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --top-module tb_channelizer -f list.f -o tb_channelizer \
    && ./obj_dir/tb_channelizer > sim.log 2>&1 \
    || { echo "build or simulation run failed"; exit 1; }
grep -q "TEST OK" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
